/* logic/mmio_macros.svh */
`ifndef MMIO_MACROS_SVH
`define MMIO_MACROS_SVH

// Region bases, matched above the in-region offset bits
`define MMIO_RAM_BASE    32'h0001_0000
`define MMIO_KEY_BASE    32'h0002_0000
`define MMIO_DISP_BASE   32'h0003_0000

// Offset bits inside one region, 4 KiB windows
`define MMIO_REGION_BITS 12

// On-chip RAM depth in 32-bit words
`define MMIO_RAM_WORDS   256

// Load data for unmapped addresses and display reads
`define MMIO_ERR_WORD    32'hDEAD_BEEF

`endif

/* logic/bus_pkg.sv */
package bus_pkg;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } mem_op_e;

    // CPU data port request, full word only
    typedef struct packed {
        logic [31:0] address;
        logic [31:0] wdata;
        mem_op_e     op;
    } cpu_req_t;

    // Wishbone classic, manager to slave
    typedef struct packed {
        logic [31:0] adr;
        logic [31:0] dat;
        logic        we;
        logic        stb;
        logic        cyc;
    } wb_m2s_t;

    // Wishbone classic, slave to manager
    typedef struct packed {
        logic [31:0] dat;
        logic        ack;
    } wb_s2m_t;

endpackage

/* logic/periph_pkg.sv */
package periph_pkg;

    typedef enum logic [1:0] {
        reg_ram  = 2'd0,
        reg_key  = 2'd1,
        reg_disp = 2'd2,
        reg_none = 2'd3
    } region_e;

    // Raw event from the keypad scanner
    typedef struct packed {
        logic [4:0] button;
        logic [1:0] app;
        logic       rising;
    } key_event_t;

    // Stored record, valid in the top bit
    typedef struct packed {
        logic       valid;
        logic [1:0] app;
        logic [4:0] button;
    } key_rec_t;

    // Display window request
    typedef struct packed {
        logic [31:0] address;
        logic [31:0] data;
        logic        wen;
    } disp_req_t;

endpackage

/* logic/wishbone_manager.sv */
module wishbone_manager (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              start,
    input  bus_pkg::cpu_req_t req_in,
    input  bus_pkg::wb_s2m_t  wb_in,
    output bus_pkg::wb_m2s_t  wb_out,
    output logic [31:0]       rdata,
    output logic              done
);
    import bus_pkg::*;

    typedef enum logic {
        idle,
        bus
    } mgr_state_e;

    mgr_state_e  state;
    logic [31:0] adr_q;
    logic [31:0] dat_q;
    logic        we_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (start) begin
                        state <= bus;
                    end
                end
                bus: begin
                    // Single classic cycle, released on the slave ack
                    if (wb_in.ack) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Request held for the whole bus cycle
    always_ff @(posedge clk) begin
        if (state == idle && start) begin
            adr_q <= req_in.address;
            dat_q <= req_in.wdata;
            we_q  <= (req_in.op == op_write);
        end
    end

    assign done = (state == bus) && wb_in.ack;

    // Load data kept until the next read completes
    always_ff @(posedge clk) begin
        if (done && !we_q) begin
            rdata <= wb_in.dat;
        end
    end

    always_comb begin
        wb_out.adr = adr_q;
        wb_out.dat = dat_q;
        wb_out.we  = we_q;
        wb_out.stb = (state == bus);
        wb_out.cyc = (state == bus);
    end

endmodule

/* logic/wishbone_ram.sv */
`include "mmio_macros.svh"

module wishbone_ram (
    input  logic             clk,
    input  logic             arst_n,
    input  bus_pkg::wb_m2s_t wb_in,
    output bus_pkg::wb_s2m_t wb_out
);
    localparam int unsigned addr_w = $clog2(`MMIO_RAM_WORDS);

    logic [31:0]       mem [`MMIO_RAM_WORDS];
    logic [addr_w-1:0] index;
    logic              hit;
    logic [31:0]       dat_q;
    logic              ack_q;

    // Word index inside the region, byte offset dropped
    assign index = wb_in.adr[addr_w+1:2];

    // Only a fresh strobe, the pending ack blocks a second one
    assign hit = wb_in.cyc && wb_in.stb && !ack_q;

    always_ff @(posedge clk) begin
        if (hit) begin
            if (wb_in.we) begin
                mem[index] <= wb_in.dat;
            end
            dat_q <= mem[index];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= hit;
        end
    end

    assign wb_out = '{dat: dat_q, ack: ack_q};

endmodule

/* logic/address_decoder.sv */
`include "mmio_macros.svh"

module address_decoder (
    input  logic                req,
    input  bus_pkg::cpu_req_t   cpu_req,
    output periph_pkg::region_e region,
    output logic                disp_wen
);
    import bus_pkg::*;
    import periph_pkg::*;

    localparam logic [31:0] offset_mask = (32'd1 << `MMIO_REGION_BITS) - 32'd1;

    logic [31:0] page;

    // Region part of the address, offset bits cleared
    assign page = cpu_req.address & ~offset_mask;

    always_comb begin
        if (page == (`MMIO_RAM_BASE & ~offset_mask)) begin
            region = reg_ram;
        end else if (page == (`MMIO_KEY_BASE & ~offset_mask)) begin
            region = reg_key;
        end else if (page == (`MMIO_DISP_BASE & ~offset_mask) && cpu_req.op == op_write) begin
            region = reg_disp;
        end else begin
            // Display reads land here too, the window is write-only
            region = reg_none;
        end
    end

    assign disp_wen = req && (region == reg_disp);

endmodule

/* logic/keypad_register.sv */
module keypad_register (
    input  logic                   clk,
    input  logic                   arst_n,
    input  periph_pkg::key_event_t key_evt,
    input  logic                   key_read,
    output periph_pkg::key_rec_t   key_rec
);
    logic rise_q;
    logic key_edge;

    // Scanner strobe going high marks a new key
    assign key_edge = key_evt.rising && !rise_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rise_q  <= 1'b0;
            key_rec <= '0;
        end else begin
            rise_q <= key_evt.rising;
            if (key_edge) begin
                // New key wins over a read in the same cycle
                key_rec.valid  <= 1'b1;
                key_rec.app    <= key_evt.app;
                key_rec.button <= key_evt.button;
            end else if (key_read) begin
                key_rec.valid <= 1'b0;
            end
        end
    end

endmodule

/* logic/ack_center.sv */
module ack_center (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                req,
    input  periph_pkg::region_e region,
    input  logic                ram_done,
    input  logic                disp_ack,
    output logic                ack,
    output logic                ram_start,
    output logic                key_read
);
    import periph_pkg::*;

    typedef enum logic [1:0] {
        idle,
        wait_ram,
        wait_disp,
        acked
    } ack_state_e;

    ack_state_e state;
    logic       is_key;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= idle;
            ack       <= 1'b0;
            ram_start <= 1'b0;
            key_read  <= 1'b0;
            is_key    <= 1'b0;
        end else begin
            ram_start <= 1'b0;
            key_read  <= 1'b0;
            case (state)
                idle: begin
                    // Ack from the previous release drops here
                    ack <= 1'b0;
                    if (req) begin
                        is_key <= (region == reg_key);
                        case (region)
                            reg_ram: begin
                                state     <= wait_ram;
                                ram_start <= 1'b1;
                            end
                            reg_disp: state <= wait_disp;
                            default:  state <= acked;
                        endcase
                    end
                end
                wait_ram: begin
                    if (ram_done) begin
                        state <= acked;
                        ack   <= 1'b1;
                    end
                end
                wait_disp: begin
                    if (disp_ack) begin
                        state <= acked;
                        ack   <= 1'b1;
                    end
                end
                acked: begin
                    ack <= 1'b1;
                    if (!req) begin
                        state    <= idle;
                        // Keypad record consumed once the CPU lets go
                        key_read <= is_key;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

endmodule

/* logic/mmio_hub.sv */
`include "mmio_macros.svh"

module mmio_hub (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   req,
    input  bus_pkg::cpu_req_t      cpu_req,
    input  periph_pkg::key_event_t key_evt,
    input  logic                   disp_ack,
    output logic                   ack,
    output logic [31:0]            rdata,
    output periph_pkg::disp_req_t  disp_req
);
    import bus_pkg::*;
    import periph_pkg::*;

    region_e     region;
    logic        disp_wen;
    logic        ram_start;
    logic        ram_done;
    logic [31:0] ram_rdata;
    logic        key_done;
    logic        key_read;
    key_rec_t    key_rec;
    wb_m2s_t     wb_m2s;
    wb_s2m_t     wb_s2m;
    mem_op_e     op_q;

    address_decoder address_decoder_i (
        .req      (req),
        .cpu_req  (cpu_req),
        .region   (region),
        .disp_wen (disp_wen)
    );

    ack_center ack_center_i (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .region    (region),
        .ram_done  (ram_done),
        .disp_ack  (disp_ack),
        .ack       (ack),
        .ram_start (ram_start),
        .key_read  (key_done)
    );

    wishbone_manager wishbone_manager_i (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (ram_start),
        .req_in (cpu_req),
        .wb_in  (wb_s2m),
        .wb_out (wb_m2s),
        .rdata  (ram_rdata),
        .done   (ram_done)
    );

    wishbone_ram wishbone_ram_i (
        .clk    (clk),
        .arst_n (arst_n),
        .wb_in  (wb_m2s),
        .wb_out (wb_s2m)
    );

    // Op of the last request, still there after req drops
    always_ff @(posedge clk) begin
        if (req) begin
            op_q <= cpu_req.op;
        end
    end

    // Only keypad loads consume the record
    assign key_read = key_done && (op_q == op_read);

    keypad_register keypad_register_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .key_evt  (key_evt),
        .key_read (key_read),
        .key_rec  (key_rec)
    );

    always_comb begin
        case (region)
            reg_ram: rdata = ram_rdata;
            reg_key: rdata = {24'd0, key_rec};
            default: rdata = `MMIO_ERR_WORD;
        endcase
    end

    assign disp_req = '{address: cpu_req.address, data: cpu_req.wdata, wen: disp_wen};

endmodule

/* tests/mmio_hub_tb.sv */
`include "mmio_macros.svh"

module mmio_hub_tb;
    import bus_pkg::*;
    import periph_pkg::*;

    localparam int clk_period        = 100;
    localparam int drive_dly         = 10;
    localparam int model_dly         = 30;
    localparam int access_limit      = 30;
    localparam int entry_cycle_bound = 40;

    typedef enum logic {
        kind_cpu,
        kind_key
    } kind_e;

    // One row of the operation table
    typedef struct packed {
        kind_e       kind;
        mem_op_e     op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp_rdata;
        logic        check;
    } entry_t;

    logic        clk;
    logic        arst_n;
    logic        req;
    cpu_req_t    cpu_req;
    key_event_t  key_evt;
    logic        disp_ack;
    logic        ack;
    logic [31:0] rdata;
    disp_req_t   disp_req;

    entry_t      ops[$];
    logic [31:0] ref_mem [`MMIO_RAM_WORDS];
    logic [31:0] lfsr_state = 32'd50;
    logic        table_done = 1'b0;
    int          errors = 0;
    int          checks = 0;

    mmio_hub mmio_hub_i (
        .clk      (clk),
        .arst_n   (arst_n),
        .req      (req),
        .cpu_req  (cpu_req),
        .key_evt  (key_evt),
        .disp_ack (disp_ack),
        .ack      (ack),
        .rdata    (rdata),
        .disp_req (disp_req)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Galois LFSR stepped once per bit taken
    function automatic logic lfsr_bit();
        logic lsb;
        lsb = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (lsb) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return lsb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic logic in_region(input logic [31:0] addr, input logic [31:0] base);
        return (addr >> `MMIO_REGION_BITS) == (base >> `MMIO_REGION_BITS);
    endfunction

    function automatic int unsigned word_index(input logic [31:0] addr);
        return (addr >> 2) % `MMIO_RAM_WORDS;
    endfunction

    task automatic to_drive_point();
        @(posedge clk);
        #(drive_dly);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond === 1'b1) else begin
            $display("Handshake error: %s", what);
            errors++;
        end
    endtask

    task automatic add_entry(input kind_e kind, input mem_op_e op, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [31:0] exp_rdata,
                             input logic check);
        ops.push_back('{kind, op, addr, wdata, exp_rdata, check});
    endtask

    task automatic build_ops();
        logic [31:0] addr [5];
        logic [31:0] data;
        logic [6:0]  key_code;
        for (int i = 0; i < 5; i++) begin
            addr[i] = `MMIO_RAM_BASE + (rand_bits(8) << 2);
            data = rand_bits(32);
            ref_mem[word_index(addr[i])] = data;
            add_entry(kind_cpu, op_write, addr[i], data, '0, 1'b0);
        end
        // Reads follow all writes so a repeated index returns the last value
        for (int i = 0; i < 5; i++) begin
            add_entry(kind_cpu, op_read, addr[i], '0, ref_mem[word_index(addr[i])], 1'b1);
        end
        // Button 0x13 from app 2
        key_code = {2'd2, 5'h13};
        add_entry(kind_key, op_read, '0, {25'd0, key_code}, '0, 1'b0);
        // A keypad store must not consume the record
        add_entry(kind_cpu, op_write, `MMIO_KEY_BASE, 32'h0000_00ff, '0, 1'b0);
        add_entry(kind_cpu, op_read, `MMIO_KEY_BASE, '0, {24'd0, 1'b1, key_code}, 1'b1);
        add_entry(kind_cpu, op_read, `MMIO_KEY_BASE, '0, {24'd0, 1'b0, key_code}, 1'b1);
        add_entry(kind_cpu, op_write, `MMIO_DISP_BASE + 32'h10, rand_bits(32), '0, 1'b0);
        add_entry(kind_cpu, op_write, `MMIO_DISP_BASE + 32'h24, rand_bits(32), '0, 1'b0);
        add_entry(kind_cpu, op_read, `MMIO_DISP_BASE + 32'h10, '0, `MMIO_ERR_WORD, 1'b1);
        add_entry(kind_cpu, op_read, 32'h0005_0040, '0, `MMIO_ERR_WORD, 1'b1);
        add_entry(kind_cpu, op_write, 32'h0000_0100, 32'h1234_5678, '0, 1'b0);
        // Overwrite of the first RAM word
        data = rand_bits(32);
        ref_mem[word_index(addr[0])] = data;
        add_entry(kind_cpu, op_write, addr[0], data, '0, 1'b0);
        add_entry(kind_cpu, op_read, addr[0], '0, data, 1'b1);
        table_done = 1'b1;
    endtask

    task automatic run_key_event(input entry_t e);
        key_evt.button = e.wdata[4:0];
        key_evt.app    = e.wdata[6:5];
        key_evt.rising = 1'b1;
        to_drive_point();
        to_drive_point();
        key_evt.rising = 1'b0;
        to_drive_point();
        to_drive_point();
    endtask

    // Starts and ends at a drive point with ack low
    task automatic run_access(input entry_t e);
        int   cyc;
        int   disp_edge;
        int   exp_lat;
        logic disp_path;
        disp_path       = in_region(e.addr, `MMIO_DISP_BASE) && e.op == op_write;
        exp_lat         = in_region(e.addr, `MMIO_RAM_BASE) ? 3 : 1;
        cyc             = 0;
        disp_edge       = -1;
        cpu_req.address = e.addr;
        cpu_req.wdata   = e.wdata;
        cpu_req.op      = e.op;
        req             = 1'b1;
        while (cyc <= access_limit) begin
            @(posedge clk);
            // Display ack as the hub samples it on this edge
            if (disp_ack && disp_edge < 0) begin
                disp_edge = cyc;
            end
            #(drive_dly);
            if (cyc == 0) begin
                check_value("disp_req.wen", disp_req.wen, disp_path);
                if (disp_path) begin
                    check_value("disp_req.address", disp_req.address, e.addr);
                    check_value("disp_req.data", disp_req.data, e.wdata);
                end
            end
            if (ack) begin
                break;
            end
            cyc++;
        end
        check_true(ack, $sformatf("no ack within %0d cycles of req", access_limit));
        if (ack) begin
            if (disp_path) begin
                check_true(disp_edge >= 0 && cyc == disp_edge,
                           $sformatf("ack in cycle %0d but display ack seen in cycle %0d",
                                     cyc, disp_edge));
            end else begin
                check_true(cyc == exp_lat,
                           $sformatf("ack rose %0d cycles after req, expected %0d",
                                     cyc, exp_lat));
            end
            if (e.check) begin
                check_value("rdata", rdata, e.exp_rdata);
            end
        end
        to_drive_point();
        check_true(ack, "ack dropped while req was still high");
        req = 1'b0;
        to_drive_point();
        check_true(ack, "ack dropped on the edge that first saw req low");
        to_drive_point();
        check_true(!ack, "ack still high one cycle after req was seen low");
    endtask

    // Display model answers wen after an LFSR delay of 1 to 8 cycles
    initial begin
        int unsigned wait_cycles;
        disp_ack = 1'b0;
        forever begin
            @(posedge clk);
            #(model_dly);
            if (disp_req.wen) begin
                wait_cycles = 1 + rand_bits(3);
                repeat (wait_cycles) begin
                    @(posedge clk);
                    #(model_dly);
                end
                disp_ack = 1'b1;
                while (disp_req.wen) begin
                    @(posedge clk);
                    #(model_dly);
                end
                disp_ack = 1'b0;
            end
        end
    end

    initial begin
        wait (table_done);
        #((ops.size() + 2) * entry_cycle_bound * clk_period);
        $display("Watchdog expired after %0d cycles per table entry", entry_cycle_bound);
        $display("Verification failed");
        $finish;
    end

    initial begin
        int    errs_before;
        string desc;
        arst_n  = 1'b0;
        req     = 1'b0;
        cpu_req = '0;
        key_evt = '0;
        build_ops();
        repeat (8) begin
            @(posedge clk);
        end
        #(drive_dly);
        arst_n = 1'b1;
        check_value("ack", ack, 32'd0);
        check_value("disp_req.wen", disp_req.wen, 32'd0);
        $display("reset: %s", errors == 0 ? "ok" : "errors");
        foreach (ops[i]) begin
            errs_before = errors;
            if (ops[i].kind == kind_key) begin
                desc = "key event";
                run_key_event(ops[i]);
            end else begin
                desc = $sformatf("%s %h", ops[i].op.name(), ops[i].addr);
                run_access(ops[i]);
            end
            to_drive_point();
            $display("entry %0d %s: %s", i, desc,
                     errors == errs_before ? "ok" : "errors");
        end
        $display("%0d entries, %0d checks, %0d errors", ops.size(), checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+logic
logic/bus_pkg.sv
logic/periph_pkg.sv
logic/wishbone_manager.sv
logic/wishbone_ram.sv
logic/address_decoder.sv
logic/keypad_register.sv
logic/ack_center.sv
logic/mmio_hub.sv
tests/mmio_hub_tb.sv

/* Bender.yml */
package:
  name: mmio_hub

sources:
  - include_dirs:
      - logic
    files:
      - logic/bus_pkg.sv
      - logic/periph_pkg.sv
      - logic/wishbone_manager.sv
      - logic/wishbone_ram.sv
      - logic/address_decoder.sv
      - logic/keypad_register.sv
      - logic/ack_center.sv
      - logic/mmio_hub.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/mmio_hub_tb.sv
